// File: rtl/wallySettings_settings.svh
`ifndef WALLY_SETTINGS_SETTINGS_SVH
`define WALLY_SETTINGS_SETTINGS_SVH

////////////////////////////////////////
// hart configuration
////////////////////////////////////////

// integer register and address width
`define XLEN 32

// first fetch address after reset
`define RESET_VECTOR 'h0

// architectural integer registers, x0 included
`define NUM_REGS 32

`endif

// File: rtl/wallyPkg.sv
`include "wallySettings_settings.svh"

package wallyPkg;

  ////////////////////////////////////////
  // encodings
  ////////////////////////////////////////

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    BRANCH = 7'b1100011,
    JAL    = 7'b1101111
  } opcodeT;

  // alu functions, PASS_B feeds lui straight through
  typedef enum logic [2:0] {
    ADD,
    SUB,
    AND,
    OR,
    XOR,
    SLT,
    PASS_B
  } aluOpT;

  // writeback source
  typedef enum logic [1:0] {
    RES_ALU,
    RES_MEM,
    RES_PC4
  } resultSrcT;

  // data port state
  typedef enum logic {
    IDLE,
    WAIT
  } memStateT;

  ////////////////////////////////////////
  // stage bundles
  ////////////////////////////////////////

  // control bundle, all zero is a bubble
  typedef struct packed {
    logic                          regWrite;
    logic                          memRead;
    logic                          memWrite;
    logic                          branch;
    logic                          branchNe;
    logic                          jump;
    logic                          aluSrcImm;
    aluOpT                         aluOp;
    resultSrcT                     resultSrc;
    logic [$clog2(`NUM_REGS)-1:0]  rd;
  } ctrlT;

  // operand fields leaving decode
  typedef struct packed {
    logic [$clog2(`NUM_REGS)-1:0]  rs1;
    logic [$clog2(`NUM_REGS)-1:0]  rs2;
    logic [`XLEN-1:0]              imm;
    logic [`XLEN-1:0]              pc;
  } decodedT;

endpackage

// File: rtl/instrFetchUnit.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module instrFetchUnit (
  input  logic             clk, reset,
  input  logic             StallF, StallD, FlushD,
  input  logic             PCSrcE,
  input  logic [`XLEN-1:0] PCTargetE,
  input  logic [31:0]      InstrF,
  output logic [`XLEN-1:0] PCF,
  output logic [31:0]      InstrD,
  output logic [`XLEN-1:0] PCD
);

  // addi x0,x0,0
  localparam logic [31:0] nopInstr = 32'h0000_0013;

  logic [`XLEN-1:0] pcNextF;

  // not-taken assumption, redirect only from a resolved branch in E
  assign pcNextF = PCSrcE ? PCTargetE : PCF + `XLEN'(4);

  // program counter
  always_ff @(posedge clk) begin
    if (reset) begin
      PCF <= `XLEN'(`RESET_VECTOR);
    end else if (!StallF) begin
      PCF <= pcNextF;
    end
  end

  ////////////////////////////////////////
  // F to D register
  ////////////////////////////////////////

  // flush turns the wrong-path fetch into a nop
  always_ff @(posedge clk) begin
    if (reset || FlushD) begin
      InstrD <= nopInstr;
      PCD    <= '0;
    end else if (!StallD) begin
      InstrD <= InstrF;
      PCD    <= PCF;
    end
  end

endmodule

// File: rtl/intController.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module intController import wallyPkg::*; (
  input  logic             clk, reset,
  input  logic [31:0]      InstrD,
  input  logic [`XLEN-1:0] PCD,
  input  logic             StallE, StallM, StallW,
  input  logic             FlushE, FlushW,
  output decodedT          DecodedD,
  output ctrlT             CtrlE, CtrlM, CtrlW
);

  opcodeT           opcodeD;
  logic [2:0]       funct3D;
  logic             funct7b5D;
  logic [`XLEN-1:0] immI, immS, immB, immU, immJ;
  logic [`XLEN-1:0] immD;
  logic             usesRs1, usesRs2;
  ctrlT             ctrlD;

  assign opcodeD   = opcodeT'(InstrD[6:0]);
  assign funct3D   = InstrD[14:12];
  assign funct7b5D = InstrD[30];

  // immediate formats
  assign immI = {{20{InstrD[31]}}, InstrD[31:20]};
  assign immS = {{20{InstrD[31]}}, InstrD[31:25], InstrD[11:7]};
  assign immB = {{19{InstrD[31]}}, InstrD[31], InstrD[7], InstrD[30:25], InstrD[11:8], 1'b0};
  assign immU = {InstrD[31:12], 12'b0};
  assign immJ = {{11{InstrD[31]}}, InstrD[31], InstrD[19:12], InstrD[20], InstrD[30:21], 1'b0};

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  always_comb begin
    // unsupported encodings fall out as a bubble
    ctrlD   = '0;
    immD    = immI;
    usesRs1 = 1'b0;
    usesRs2 = 1'b0;
    case (opcodeD)
      OP: begin
        usesRs1        = 1'b1;
        usesRs2        = 1'b1;
        ctrlD.regWrite = 1'b1;
        case (funct3D)
          3'b000:  ctrlD.aluOp = funct7b5D ? SUB : ADD;
          3'b111:  ctrlD.aluOp = AND;
          3'b110:  ctrlD.aluOp = OR;
          3'b100:  ctrlD.aluOp = XOR;
          3'b010:  ctrlD.aluOp = SLT;
          default: ctrlD.regWrite = 1'b0;
        endcase
      end
      OP_IMM: begin
        // addi only
        usesRs1         = 1'b1;
        ctrlD.regWrite  = (funct3D == 3'b000);
        ctrlD.aluSrcImm = 1'b1;
      end
      LUI: begin
        immD            = immU;
        ctrlD.regWrite  = 1'b1;
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.aluOp     = PASS_B;
      end
      LOAD: begin
        // lw only
        usesRs1         = 1'b1;
        ctrlD.memRead   = (funct3D == 3'b010);
        ctrlD.regWrite  = (funct3D == 3'b010);
        ctrlD.aluSrcImm = 1'b1;
        ctrlD.resultSrc = RES_MEM;
      end
      STORE: begin
        usesRs1         = 1'b1;
        usesRs2         = 1'b1;
        immD            = immS;
        ctrlD.memWrite  = (funct3D == 3'b010);
        ctrlD.aluSrcImm = 1'b1;
      end
      BRANCH: begin
        // beq and bne
        usesRs1        = 1'b1;
        usesRs2        = 1'b1;
        immD           = immB;
        ctrlD.branch   = (funct3D[2:1] == 2'b00);
        ctrlD.branchNe = funct3D[0];
      end
      JAL: begin
        immD            = immJ;
        ctrlD.regWrite  = 1'b1;
        ctrlD.jump      = 1'b1;
        ctrlD.resultSrc = RES_PC4;
      end
      default: ctrlD = '0;
    endcase
    ctrlD.rd = InstrD[11:7];
    // x0 destination never writes back, so no false forwarding later
    if (ctrlD.rd == '0) begin
      ctrlD.regWrite = 1'b0;
    end
  end

  // unused source fields read as x0 to avoid false hazards
  assign DecodedD.rs1 = usesRs1 ? InstrD[19:15] : '0;
  assign DecodedD.rs2 = usesRs2 ? InstrD[24:20] : '0;
  assign DecodedD.imm = immD;
  assign DecodedD.pc  = PCD;

  ////////////////////////////////////////
  // control pipeline D to W
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset || FlushE) begin
      CtrlE <= '0;
    end else if (!StallE) begin
      CtrlE <= ctrlD;
    end
  end

  // M only ever holds, never flushed
  always_ff @(posedge clk) begin
    if (reset) begin
      CtrlM <= '0;
    end else if (!StallM) begin
      CtrlM <= CtrlE;
    end
  end

  always_ff @(posedge clk) begin
    if (reset || FlushW) begin
      CtrlW <= '0;
    end else if (!StallW) begin
      CtrlW <= CtrlM;
    end
  end

  // illegal opcode in D must arrive in E as a bubble
  assert property (@(posedge clk) disable iff (reset)
    (!(opcodeD inside {OP, OP_IMM, LUI, LOAD, STORE, BRANCH, JAL}) && !StallE && !FlushE)
    |=> !(CtrlE.regWrite || CtrlE.memRead || CtrlE.memWrite));

endmodule

// File: rtl/regFile.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module regFile (
  input  logic                         clk, reset,
  input  logic                         WriteEnW,
  input  logic [$clog2(`NUM_REGS)-1:0] Rs1D, Rs2D, RdW,
  input  logic [`XLEN-1:0]             ResultW,
  output logic [`XLEN-1:0]             Rd1D, Rd2D
);

  logic [`XLEN-1:0] regs [`NUM_REGS];
  logic             realWriteW;

  // writes to x0 are dropped
  assign realWriteW = WriteEnW && (RdW != '0);

  // x0 is cleared by reset and never written again
  always_ff @(posedge clk) begin
    if (reset) begin
      regs[0] <= '0;
    end else if (realWriteW) begin
      regs[RdW] <= ResultW;
    end
  end

  // W result bypassed into D in the same cycle
  assign Rd1D = (realWriteW && RdW == Rs1D) ? ResultW : regs[Rs1D];
  assign Rd2D = (realWriteW && RdW == Rs2D) ? ResultW : regs[Rs2D];

  // x0 reads zero on both ports
  assert property (@(posedge clk) disable iff (reset) (Rs1D == '0) |-> (Rd1D == '0));
  assert property (@(posedge clk) disable iff (reset) (Rs2D == '0) |-> (Rd2D == '0));

endmodule

// File: rtl/intDatapath.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module intDatapath import wallyPkg::*; (
  input  logic             clk, reset,
  input  decodedT          DecodedD,
  input  logic [`XLEN-1:0] Rd1D, Rd2D,
  input  ctrlT             CtrlE, CtrlM, CtrlW,
  input  logic [1:0]       ForwardAE, ForwardBE,
  input  logic             StallE, StallM, StallW, FlushE,
  input  logic [`XLEN-1:0] ReadDataM,
  output logic             PCSrcE,
  output logic [`XLEN-1:0] PCTargetE,
  output logic [`XLEN-1:0] AluResultM, StoreDataM,
  output logic [`XLEN-1:0] ResultW
);

  logic [`XLEN-1:0] rd1E, rd2E, immE, pcE;
  logic [1:0]       fwdSelAE, fwdSelBE;
  logic [`XLEN-1:0] srcAE, fwdBE, srcBE;
  logic [`XLEN-1:0] aluResultE, exeResultE;
  logic             equalE;
  logic [`XLEN-1:0] aluResultW, readDataW;

  // 2'b10 from M, 2'b01 from W, else register value
  function automatic logic [`XLEN-1:0] fwdMux(input logic [1:0] sel,
                                              input logic [`XLEN-1:0] regVal,
                                              input logic [`XLEN-1:0] mVal,
                                              input logic [`XLEN-1:0] wVal);
    case (sel)
      2'b10:   return mVal;
      2'b01:   return wVal;
      default: return regVal;
    endcase
  endfunction

  ////////////////////////////////////////
  // D to E register
  ////////////////////////////////////////

  // selects come from the hazard unit while the instruction is in D
  always_ff @(posedge clk) begin
    if (reset || FlushE || StallE) begin
      fwdSelAE <= 2'b00;
      fwdSelBE <= 2'b00;
    end else begin
      fwdSelAE <= ForwardAE;
      fwdSelBE <= ForwardBE;
    end
  end

  // a stalled E keeps its operands up to date
  // the W producer may retire while E waits
  always_ff @(posedge clk) begin
    if (StallE) begin
      rd1E <= srcAE;
      rd2E <= fwdBE;
    end else begin
      rd1E <= Rd1D;
      rd2E <= Rd2D;
      immE <= DecodedD.imm;
      pcE  <= DecodedD.pc;
    end
  end

  ////////////////////////////////////////
  // execute
  ////////////////////////////////////////

  assign srcAE = fwdMux(fwdSelAE, rd1E, AluResultM, ResultW);
  assign fwdBE = fwdMux(fwdSelBE, rd2E, AluResultM, ResultW);
  assign srcBE = CtrlE.aluSrcImm ? immE : fwdBE;

  always_comb begin
    case (CtrlE.aluOp)
      ADD:     aluResultE = srcAE + srcBE;
      SUB:     aluResultE = srcAE - srcBE;
      AND:     aluResultE = srcAE & srcBE;
      OR:      aluResultE = srcAE | srcBE;
      XOR:     aluResultE = srcAE ^ srcBE;
      SLT:     aluResultE = {{(`XLEN-1){1'b0}}, ($signed(srcAE) < $signed(srcBE))};
      PASS_B:  aluResultE = srcBE;
      default: aluResultE = srcAE + srcBE;
    endcase
  end

  // jal link value rides in the alu result slot
  assign exeResultE = (CtrlE.resultSrc == RES_PC4) ? pcE + `XLEN'(4) : aluResultE;

  // branch compare on forwarded operands
  assign equalE    = (srcAE == fwdBE);
  assign PCSrcE    = CtrlE.jump || (CtrlE.branch && (CtrlE.branchNe ? !equalE : equalE));
  assign PCTargetE = pcE + immE;

  ////////////////////////////////////////
  // E to M and M to W
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!StallM) begin
      AluResultM <= exeResultE;
      StoreDataM <= fwdBE;
    end
  end

  // read data is captured only for loads
  always_ff @(posedge clk) begin
    if (!StallW) begin
      aluResultW <= AluResultM;
      if (CtrlM.memRead) begin
        readDataW <= ReadDataM;
      end
    end
  end

  assign ResultW = (CtrlW.resultSrc == RES_MEM) ? readDataW : aluResultW;

endmodule

// File: rtl/dataMemUnit.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module dataMemUnit import wallyPkg::*; (
  input  logic             clk, reset,
  input  ctrlT             CtrlM,
  input  logic [`XLEN-1:0] AluResultM, StoreDataM,
  input  logic             MemReadyM,
  input  logic [`XLEN-1:0] ReadDataM,
  output logic             MemReadM, MemWriteM,
  output logic [`XLEN-1:0] MemAdrM, WriteDataM,
  output logic             DataStallM
);

  memStateT         state, nextState;
  logic             accessM;

  assign accessM = CtrlM.memRead || CtrlM.memWrite;

  // strobe goes out in the cycle the bundle enters M
  assign MemReadM  = CtrlM.memRead;
  assign MemWriteM = CtrlM.memWrite;

  // request comes straight from the M register, held there by the stall
  assign MemAdrM    = AluResultM;
  assign WriteDataM = StoreDataM;

  // pipeline frozen until ready
  assign DataStallM = accessM && !MemReadyM;

  ////////////////////////////////////////
  // access FSM
  ////////////////////////////////////////

  always_comb begin
    nextState = state;
    case (state)
      IDLE:    if (accessM && !MemReadyM) nextState = WAIT;
      WAIT:    if (MemReadyM || !accessM) nextState = IDLE;
      default: nextState = IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= nextState;
    end
  end

  // one strobe at a time
  assert property (@(posedge clk) disable iff (reset) !(MemReadM && MemWriteM));

  // while waiting the request must not move, which needs M held upstream
  assert property (@(posedge clk) disable iff (reset)
    (state == WAIT) |->
      ($stable(MemAdrM) && $stable(MemReadM) && $stable(MemWriteM) && $stable(WriteDataM)));

  // memory returns known data on the completing cycle
  assert property (@(posedge clk) disable iff (reset)
    (MemReadM && MemReadyM) |-> !$isunknown(ReadDataM));

endmodule

// File: rtl/hazardUnit.sv
`timescale 1ns/10ps

module hazardUnit import wallyPkg::*; (
  input  decodedT    DecodedD,
  input  ctrlT       CtrlE, CtrlM, CtrlW,
  input  logic       PCSrcE,
  input  logic       DataStallM,
  output logic       StallF, StallD, StallE, StallM, StallW,
  output logic       FlushD, FlushE, FlushW,
  output logic [1:0] ForwardAE, ForwardBE
);

  logic loadUseD;

  // evaluated for the instruction in D
  // E producer lands in M, M producer lands in W
  // W producer is covered by the register file bypass
  function automatic logic [1:0] fwdSel(input logic [4:0] rs,
                                        input ctrlT toM,
                                        input ctrlT toW);
    if (rs != '0 && toM.regWrite && toM.rd == rs) begin
      return 2'b10;
    end else if (rs != '0 && toW.regWrite && toW.rd == rs) begin
      return 2'b01;
    end
    return 2'b00;
  endfunction

  assign ForwardAE = fwdSel(DecodedD.rs1, CtrlE, CtrlM);
  assign ForwardBE = fwdSel(DecodedD.rs2, CtrlE, CtrlM);

  ////////////////////////////////////////
  // stall and flush
  ////////////////////////////////////////

  // load in E feeding D, one bubble
  assign loadUseD = CtrlE.memRead && (CtrlE.rd != '0) &&
                    ((CtrlE.rd == DecodedD.rs1) || (CtrlE.rd == DecodedD.rs2));

  // data port back-pressure freezes F through M
  assign StallM = DataStallM;
  assign StallE = DataStallM;
  assign StallD = DataStallM || loadUseD;
  assign StallF = StallD;
  // W always drains
  assign StallW = 1'b0;

  // taken branch kills the two younger stages unless they hold
  assign FlushD = PCSrcE && !StallD;
  assign FlushE = (PCSrcE || loadUseD) && !StallE;
  // M held, so W gets a bubble
  assign FlushW = DataStallM;

  // no clock here, so checked combinationally
  always_comb begin
    assert (!(StallD && FlushD) && !(StallE && FlushE) && !(StallW && FlushW));
    // decode never lets an x0 write reach writeback
    assert (!(CtrlW.regWrite && CtrlW.rd == '0));
  end

endmodule

// File: rtl/wallyPipelinedHart.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module wallyPipelinedHart import wallyPkg::*; (
  input  logic             clk, reset,
  // instruction port
  output logic [`XLEN-1:0] PCF,
  input  logic [31:0]      InstrF,
  // data port
  output logic             MemReadM, MemWriteM,
  output logic [`XLEN-1:0] MemAdrM, WriteDataM,
  input  logic [`XLEN-1:0] ReadDataM,
  input  logic             MemReadyM
);

  ////////////////////////////////////////
  // pipeline wires
  ////////////////////////////////////////

  // hazard control
  logic             StallF, StallD, StallE, StallM, StallW;
  logic             FlushD, FlushE, FlushW;
  logic [1:0]       ForwardAE, ForwardBE;
  logic             DataStallM;

  // fetch and decode
  logic [31:0]      InstrD;
  logic [`XLEN-1:0] PCD;
  decodedT          DecodedD;
  ctrlT             CtrlE, CtrlM, CtrlW;
  logic [`XLEN-1:0] Rd1D, Rd2D;

  // execute through writeback
  logic             PCSrcE;
  logic [`XLEN-1:0] PCTargetE;
  logic [`XLEN-1:0] AluResultM, StoreDataM;
  logic [`XLEN-1:0] ResultW;

  // PC, next-PC select and F/D register
  instrFetchUnit ifu (.*);

  // integer execution: decode and control pipeline, register file, datapath
  intController ctrl (.*);

  regFile rf (
    .clk      (clk),
    .reset    (reset),
    .WriteEnW (CtrlW.regWrite),
    .Rs1D     (DecodedD.rs1),
    .Rs2D     (DecodedD.rs2),
    .RdW      (CtrlW.rd),
    .ResultW  (ResultW),
    .Rd1D     (Rd1D),
    .Rd2D     (Rd2D)
  );

  intDatapath dp (.*);

  // load/store strobes and back-pressure
  dataMemUnit dmu (.*);

  // global stall, flush and forwarding control
  hazardUnit hzu (.*);

endmodule

// File: verification/hartRefModel.svh
`ifndef HART_REF_MODEL_SVH
`define HART_REF_MODEL_SVH

////////////////////////////////////////
// rv32i encoders
////////////////////////////////////////

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3,
                                     input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd,
                                     input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

// word store, base + offset
function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2,
                                     input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] encB(input logic [12:0] off, input logic [4:0] rs2,
                                     input logic [4:0] rs1, input logic [2:0] f3);
  return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'h63};
endfunction

function automatic logic [31:0] encJ(input logic [20:0] off, input logic [4:0] rd);
  return {off[20], off[10:1], off[11], off[19:12], rd, 7'h6f};
endfunction

// initial data memory word, scrambled over the whole index
function automatic logic [31:0] fillWord(input logic [7:0] idx);
  return 32'h9E37_79B9 * {24'd0, idx} + 32'h1234_5677;
endfunction

// small pool keeps dependencies dense
function automatic logic [4:0] pickReg(input bit x0Heavy);
  if (x0Heavy && $urandom_range(0, 1) == 1) begin
    return 5'd0;
  end
  return 5'($urandom_range(0, 7));
endfunction

////////////////////////////////////////
// random program
////////////////////////////////////////

// mode 0 alu only, 1 adds memory, 2 and up add control flow, 3 favours x0
function automatic void genProgram(input int mode);
  int          i, idx, bodyEnd, maxKind, kind, skip, sel;
  logic [4:0]  rd, rs1, rs2;
  logic [11:0] imm;
  logic [2:0]  f3;
  for (i = 0; i < 256; i++) begin
    imem[i] = 32'h0000_0013;
  end
  // every register gets a known value first
  idx = 0;
  for (i = 1; i < 32; i++) begin
    imem[idx] = encI(12'($urandom_range(0, 4095)), 5'd0, 3'b000, 5'(i), 7'h13);
    idx++;
  end
  bodyEnd = idx + 60;
  maxKind = (mode == 0) ? 2 : ((mode == 1) ? 4 : 6);
  while (idx < bodyEnd) begin
    rd   = pickReg(mode == 3);
    rs1  = pickReg(1'b0);
    rs2  = pickReg(1'b0);
    imm  = 12'($urandom_range(0, 4095));
    kind = $urandom_range(0, maxKind);
    case (kind)
      0: begin
        sel = $urandom_range(0, 5);
        case (sel)
          0, 1:    f3 = 3'b000;
          2:       f3 = 3'b111;
          3:       f3 = 3'b110;
          4:       f3 = 3'b100;
          default: f3 = 3'b010;
        endcase
        // sel 1 is sub
        imem[idx] = encR((sel == 1) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
      end
      1: imem[idx] = encI(imm, rs1, 3'b000, rd, 7'h13);
      2: imem[idx] = {20'($urandom()), rd, 7'h37};
      3: begin
        // load, then its value used right away
        imem[idx] = encI(12'(4 * $urandom_range(0, 15)), 5'd0, 3'b010, rd, 7'h03);
        if (idx + 1 < bodyEnd) begin
          idx++;
          imem[idx] = encR(7'h00, rs2, rd, 3'b000, pickReg(mode == 3));
        end
      end
      4: imem[idx] = encS(12'(4 * $urandom_range(0, 15)), rs2, 5'd0);
      default: begin
        // forward only, never past the register dump
        skip = $urandom_range(1, 3);
        if (skip > bodyEnd - idx - 1) begin
          skip = bodyEnd - idx - 1;
        end
        if (skip < 1) begin
          imem[idx] = encI(imm, rs1, 3'b000, rd, 7'h13);
        end else if (kind == 5) begin
          imem[idx] = encB(13'(4 * (skip + 1)), ($urandom_range(0, 3) == 0) ? rs1 : rs2,
                           rs1, 3'($urandom_range(0, 1)));
        end else begin
          imem[idx] = encJ(21'(4 * (skip + 1)), rd);
        end
      end
    endcase
    idx++;
  end
  // dump all registers, x0 included
  for (i = 0; i < 32; i++) begin
    imem[idx] = encS(12'(512 + 4 * i), 5'(i), 5'd0);
    idx++;
  end
  // jal x0,0 parks the hart
  imem[idx] = encJ(21'd0, 5'd0);
  progLen = idx + 1;
endfunction

////////////////////////////////////////
// instruction-level model
////////////////////////////////////////

// runs imem until the parking jump, collecting every load address and store in order
function automatic void refRun();
  logic [31:0] x [32];
  logic [31:0] mem [256];
  logic [31:0] pc, nextPc, ins, a, b, res, adr;
  logic [4:0]  rd;
  int          i, steps;
  for (i = 0; i < 32; i++) begin
    x[i] = 32'd0;
  end
  for (i = 0; i < 256; i++) begin
    mem[i] = fillWord(8'(i));
  end
  expAdr.delete();
  expData.delete();
  expLoadAdr.delete();
  pc    = 32'd0;
  ins   = imem[0];
  steps = 0;
  while (ins != 32'h0000_006f && steps < 1024) begin
    a      = x[ins[19:15]];
    b      = x[ins[24:20]];
    rd     = ins[11:7];
    res    = x[rd];
    nextPc = pc + 32'd4;
    case (ins[6:0])
      7'h33: begin
        case (ins[14:12])
          3'b000:  res = ins[30] ? a - b : a + b;
          3'b111:  res = a & b;
          3'b110:  res = a | b;
          3'b100:  res = a ^ b;
          default: res = {31'd0, $signed(a) < $signed(b)};
        endcase
      end
      7'h13: res = a + {{20{ins[31]}}, ins[31:20]};
      7'h37: res = {ins[31:12], 12'd0};
      7'h03: begin
        adr = a + {{20{ins[31]}}, ins[31:20]};
        res = mem[adr[9:2]];
        expLoadAdr.push_back(adr);
      end
      7'h23: begin
        adr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        mem[adr[9:2]] = b;
        expAdr.push_back(adr);
        expData.push_back(b);
      end
      7'h63: begin
        // funct3 bit 0 turns beq into bne
        if ((a == b) != ins[12]) begin
          nextPc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
        end
      end
      7'h6f: begin
        res    = pc + 32'd4;
        nextPc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
      end
      default: ;
    endcase
    // stores and branches write back the unchanged value
    x[rd] = res;
    x[0]  = 32'd0;
    pc    = nextPc;
    ins   = imem[pc[9:2]];
    steps++;
  end
endfunction

`endif

// File: verification/hartTb.sv
`timescale 1ns/10ps
`include "wallySettings_settings.svh"

module hartTb;

  logic             clk = 1'b0;
  logic             reset = 1'b1;
  logic [`XLEN-1:0] PCF;
  logic [31:0]      InstrF;
  logic             MemReadM, MemWriteM;
  logic [`XLEN-1:0] MemAdrM, WriteDataM;
  logic [`XLEN-1:0] ReadDataM = '0;
  logic             MemReadyM = 1'b1;

  // program image and data image, 1 KiB each
  logic [31:0] imem [256];
  logic [31:0] dmem [256];
  // expected stores in program order
  logic [31:0] expAdr [$];
  logic [31:0] expData [$];
  // expected load addresses in program order
  logic [31:0] expLoadAdr [$];

  int    progLen, storeIdx, loadIdx, errorCount, cycleCount;
  int    watchStart, watchLimit, testsRun, testsFailed;
  bit    randomReady = 1'b0;
  bit    watchOn = 1'b0;
  string testName;

  `include "hartRefModel.svh"

  wallyPipelinedHart DUT (.*);

  always #10 clk = ~clk;

  // instruction port answers in the same cycle
  assign InstrF = imem[PCF[9:2]];

  ////////////////////////////////////////
  // data memory
  ////////////////////////////////////////

  // ready and read data change on the falling edge only
  always @(negedge clk) begin
    MemReadyM <= randomReady ? 1'($urandom_range(0, 1)) : 1'b1;
    ReadDataM <= dmem[MemAdrM[9:2]];
  end

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errorCount++;
      $display("FAIL %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  // an access completes on a rising edge with its strobe and ready both high
  always @(posedge clk) begin : portChecker
    int i;
    if (reset) begin
      storeIdx = 0;
      loadIdx  = 0;
      for (i = 0; i < 256; i++) begin
        dmem[i] = fillWord(8'(i));
      end
    end else begin
      if (MemReadM && MemReadyM) begin
        if (loadIdx < expLoadAdr.size()) begin
          checkEq($sformatf("load %0d address", loadIdx), MemAdrM, expLoadAdr[loadIdx]);
        end else begin
          errorCount++;
          $display("%0t: extra load from %h after the expected list ran out", $time, MemAdrM);
        end
        loadIdx++;
      end
      if (MemWriteM && MemReadyM) begin
        if (storeIdx < expAdr.size()) begin
          checkEq($sformatf("store %0d address", storeIdx), MemAdrM, expAdr[storeIdx]);
          checkEq($sformatf("store %0d data", storeIdx), WriteDataM, expData[storeIdx]);
        end else begin
          errorCount++;
          $display("%0t: extra store to %h after the expected list ran out", $time, MemAdrM);
        end
        dmem[MemAdrM[9:2]] = WriteDataM;
        storeIdx++;
      end
    end
  end

  ////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
  end

  // budget is 40 cycles per program instruction
  initial begin : watchdog
    while (!(watchOn && (cycleCount - watchStart > watchLimit))) begin
      @(posedge clk);
    end
    $display("timeout: %s did not reach its last store within %0d cycles",
             testName, watchLimit);
    $display("test failed");
    $finish;
  end

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  // called on a falling edge, or at time zero
  task automatic runTest(input string name, input int mode, input bit randReady);
    int errsBefore;
    errsBefore  = errorCount;
    reset       = 1'b1;
    testName    = name;
    randomReady = randReady;
    genProgram(mode);
    refRun();
    repeat (10) @(negedge clk);
    reset      = 1'b0;
    watchStart = cycleCount;
    watchLimit = 40 * progLen;
    watchOn    = 1'b1;
    while (storeIdx < expAdr.size()) begin
      @(negedge clk);
    end
    watchOn = 1'b0;
    // every load comes before the register dump
    if (loadIdx != expLoadAdr.size()) begin
      errorCount++;
      $display("%s: %0d loads seen on the data port, %0d expected",
               name, loadIdx, expLoadAdr.size());
    end
    testsRun++;
    if (errorCount != errsBefore) begin
      testsFailed++;
    end
    $display("%s: %0d instructions, %0d stores and %0d loads checked, %0d mismatches",
             name, progLen, storeIdx, loadIdx, errorCount - errsBefore);
  endtask

  initial begin
    void'($urandom(32873));
    runTest("alu_chain", 0, 1'b0);
    runTest("load_use", 1, 1'b0);
    runTest("branch_jal", 2, 1'b0);
    runTest("x0_writes", 3, 1'b0);
    runTest("mixed", 4, 1'b0);
    runTest("mem_backpressure", 4, 1'b1);
    $display("%0d tests run, %0d with errors, %0d mismatches in total",
             testsRun, testsFailed, errorCount);
    if (errorCount == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// File: files.f
+incdir+rtl
+incdir+verification
rtl/wallyPkg.sv
rtl/instrFetchUnit.sv
rtl/intController.sv
rtl/regFile.sv
rtl/intDatapath.sv
rtl/dataMemUnit.sv
rtl/hazardUnit.sv
rtl/wallyPipelinedHart.sv
verification/hartTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the hart testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module hartTb -f files.f

# a nonzero exit from the simulator is kept and judged below
status=0
./obj_dir/VhartTb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "test failed" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ] || ! grep -q "test passed" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
exit 0
